// ==== bist/bist_sequencer.sv ====
// BIST sequencer FSM
// start and pattern handshakes, pattern counter, done pulse
`timescale 1ns/1ns
`default_nettype none

module bist_sequencer (
    input  wire  clk,
    input  wire  reset,
    input  wire  req_val,
    input  wire  pat_rdy,
    input  wire  res_val,
    output logic req_rdy,
    output logic pat_val,
    output logic start,
    output logic advance,
    output logic done
);
    import bist_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    logic [count_width-1:0] pat_count;
    logic last_result;

    assign req_rdy = (state == state_idle);

    // first pattern waits one cycle for the seed load
    assign pat_val = (state == state_gen_val) && !start;
    assign advance = pat_val && pat_rdy;

    assign last_result = (state == state_send_val) && res_val &&
                         (pat_count == count_width'(num_patterns - 1));

    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                if (req_val) begin
                    next_state = state_gen_val;
                end
            end
            state_gen_val: begin
                if (advance) begin
                    next_state = state_send_val;
                end
            end
            state_send_val: begin
                if (last_result) begin
                    next_state = state_idle;
                end
                else if (res_val) begin
                    next_state = state_gen_val;
                end
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_idle;
            start <= 1'b0;
            done  <= 1'b0;
        end
        else begin
            state <= next_state;
            start <= req_val && req_rdy;
            done  <= last_result;
        end
    end

    // wraps back to zero on the eighth result
    always_ff @(posedge clk) begin
        if (reset || start) begin
            pat_count <= '0;
        end
        else if (res_val) begin
            pat_count <= pat_count + 1'b1;
        end
    end

    // a result outside send_val would be miscounted
    result_in_send_val: assert property (
        @(posedge clk) disable iff (reset)
        res_val |-> state == state_send_val
    );

    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    );

endmodule

`default_nettype wire

// ==== bist/pattern_lfsr.sv ====
// galois LFSR pattern source
`timescale 1ns/1ns
`default_nettype none

module pattern_lfsr (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            start,
    input  wire [bist_pkg::data_width-1:0] seed,
    input  wire                            advance,
    output logic [bist_pkg::data_width-1:0] pattern
);
    import bist_pkg::*;

    // a zero seed never leaves zero
    always_ff @(posedge clk) begin
        if (reset) begin
            pattern <= '0;
        end
        else if (start) begin
            pattern <= seed;
        end
        else if (advance) begin
            pattern <= galois_step(pattern);
        end
    end

    // seed load and step in the same cycle would drop the first pattern
    start_advance_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(start && advance)
    );

endmodule

`default_nettype wire

// ==== bist/signature_misr.sv ====
// multiple-input signature register for the multiplier results
`timescale 1ns/1ns
`default_nettype none

module signature_misr (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             start,
    input  wire                             res_val,
    input  wire  [bist_pkg::data_width-1:0] product,
    output logic [bist_pkg::data_width-1:0] signature
);
    import bist_pkg::*;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            signature <= '0;
        end
        else if (res_val) begin
            // step first, then fold in the new result
            signature <= galois_step(signature) ^ product;
        end
    end

    // results only arrive after a run has started
    no_result_on_start: assert property (
        @(posedge clk) disable iff (reset)
        start |-> !res_val
    );

endmodule

`default_nettype wire

// ==== common/bist_pkg.sv ====
// widths, feedback polynomial and pattern count for the multiplier BIST
// sequencer state type and the shared galois step
`default_nettype none

package bist_pkg;

    localparam int data_width = 32;
    localparam int operand_width = 16;
    localparam int num_patterns = 8;
    localparam int count_width = $clog2(num_patterns);
    localparam int step_width = $clog2(operand_width + 1);

    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [data_width-1:0] lfsr_taps = 32'h8020_0003;

    typedef enum logic [1:0] {
        state_idle,
        state_gen_val,
        state_send_val
    } seq_state_t;

    // one right shift, fold the dropped bit back through the taps
    function automatic logic [data_width-1:0] galois_step(input logic [data_width-1:0] value);
        logic [data_width-1:0] shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ lfsr_taps;
        end
        return shifted;
    endfunction

endpackage

`default_nettype wire

// ==== lfsr_bist.f ====
common/bist_pkg.sv
bist/pattern_lfsr.sv
bist/bist_sequencer.sv
bist/signature_misr.sv
src/shift_add_multiplier.sv
src/bist_top.sv
verification/bist_tb.sv

// ==== src/bist_top.sv ====
// BIST top level
// sequencer, pattern LFSR, multiplier under test and MISR
`timescale 1ns/1ns
`default_nettype none

module bist_top (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             req_val,
    input  wire  [bist_pkg::data_width-1:0] seed,
    output logic                            req_rdy,
    output logic                            done,
    output logic [bist_pkg::data_width-1:0] signature
);
    import bist_pkg::*;

    logic pat_val;
    logic pat_rdy;
    logic res_val;
    logic start;
    logic advance;
    logic [data_width-1:0] pattern;
    logic [data_width-1:0] product;

    bist_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .req_val (req_val),
        .pat_rdy (pat_rdy),
        .res_val (res_val),
        .req_rdy (req_rdy),
        .pat_val (pat_val),
        .start   (start),
        .advance (advance),
        .done    (done)
    );

    pattern_lfsr u_lfsr (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .seed    (seed),
        .advance (advance),
        .pattern (pattern)
    );

    // circuit under test
    shift_add_multiplier u_multiplier (
        .clk     (clk),
        .reset   (reset),
        .pat_val (pat_val),
        .pattern (pattern),
        .pat_rdy (pat_rdy),
        .res_val (res_val),
        .product (product)
    );

    signature_misr u_misr (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .res_val   (res_val),
        .product   (product),
        .signature (signature)
    );

endmodule

`default_nettype wire

// ==== src/shift_add_multiplier.sv ====
// iterative 16x16 unsigned shift-add multiplier
`timescale 1ns/1ns
`default_nettype none

module shift_add_multiplier (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             pat_val,
    input  wire  [bist_pkg::data_width-1:0] pattern,
    output logic                            pat_rdy,
    output logic                            res_val,
    output logic [bist_pkg::data_width-1:0] product
);
    import bist_pkg::*;

    logic busy;
    logic take;
    logic [step_width-1:0] step_count;
    logic [data_width-1:0] mcand;
    logic [operand_width-1:0] mplier;
    logic [data_width-1:0] acc;

    assign pat_rdy = !busy;
    assign take = pat_val && pat_rdy;
    assign product = acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            step_count <= '0;
            res_val    <= 1'b0;
        end
        else begin
            res_val <= busy && (step_count == step_width'(1));
            if (take) begin
                busy       <= 1'b1;
                step_count <= step_width'(operand_width);
            end
            else if (res_val) begin
                busy <= 1'b0;
            end
            else if (step_count != '0) begin
                step_count <= step_count - 1'b1;
            end
        end
    end

    // upper half is operand a
    always_ff @(posedge clk) begin
        if (take) begin
            mcand  <= {{(data_width - operand_width){1'b0}},
                       pattern[data_width-1:operand_width]};
            mplier <= pattern[operand_width-1:0];
            acc    <= '0;
        end
        else if (step_count != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    res_val_at_finish: assert property (
        @(posedge clk) disable iff (reset)
        res_val |-> busy && step_count == '0
    );

endmodule

`default_nettype wire

// ==== verification/bist_tb.sv ====
// testbench for the multiplier BIST
// LCG seeds, signature model, handshake and done checks
`timescale 1ns/1ns
`default_nettype none

module bist_tb;
    import bist_pkg::*;

    localparam int timeout_cycles = 1000;
    localparam int random_runs = 20;
    localparam int chain_runs = 4;

    logic clk;
    logic reset;
    logic req_val;
    logic [data_width-1:0] seed;
    logic req_rdy;
    logic done;
    logic [data_width-1:0] signature;

    logic [31:0] rng_state;
    int errors;
    int checks;
    int starts;
    int done_pulses;
    logic done_last;

    bist_top uut (
        .clk       (clk),
        .reset     (reset),
        .req_val   (req_val),
        .seed      (seed),
        .req_rdy   (req_rdy),
        .done      (done),
        .signature (signature)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [data_width-1:0] nonzero_seed();
        logic [data_width-1:0] value;
        value = lcg();
        if (value == '0) begin
            value = 32'h1;
        end
        return value;
    endfunction

    // right shift, taps applied when a one drops out
    function automatic logic [data_width-1:0] model_step(input logic [data_width-1:0] value);
        logic [data_width-1:0] next_value;
        next_value = {1'b0, value[data_width-1:1]};
        if (value[0]) begin
            next_value = next_value ^ lfsr_taps;
        end
        return next_value;
    endfunction

    function automatic logic [data_width-1:0] model_signature(
        input logic [data_width-1:0] run_seed
    );
        logic [data_width-1:0] pat;
        logic [data_width-1:0] sig;
        logic [data_width-1:0] prod;
        pat = run_seed;
        sig = '0;
        for (int i = 0; i < num_patterns; i++) begin
            prod = data_width'(pat[data_width-1:operand_width]) *
                   data_width'(pat[operand_width-1:0]);
            sig = model_step(sig) ^ prod;
            pat = model_step(pat);
        end
        return sig;
    endfunction

    task automatic check_value(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // returns at the falling edge before the accepting edge
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!req_rdy && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (req_rdy) begin
            starts++;
        end
        else begin
            errors++;
            $display("timeout: start request not accepted within %0d cycles", timeout_cycles);
        end
    endtask

    task automatic wait_done(output logic seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        seen = done;
        if (!done) begin
            errors++;
            $display("timeout: no done pulse within %0d cycles", timeout_cycles);
        end
    endtask

    // seed stays on the bus until done, the LFSR loads it a cycle late
    task automatic run_single(input logic [data_width-1:0] run_seed, input int hold_cycles);
        logic seen;
        @(posedge clk);
        req_val <= 1'b1;
        seed <= run_seed;
        wait_accept();
        repeat (hold_cycles) @(posedge clk);
        req_val <= 1'b0;
        wait_done(seen);
        if (seen) begin
            check_value("signature", model_signature(run_seed), signature);
        end
    endtask

    // req_val never drops, next run is accepted in the done cycle
    task automatic run_chain();
        logic [data_width-1:0] chain_seeds [chain_runs];
        logic seen;
        for (int k = 0; k < chain_runs; k++) begin
            chain_seeds[k] = nonzero_seed();
        end
        @(posedge clk);
        req_val <= 1'b1;
        seed <= chain_seeds[0];
        wait_accept();
        for (int k = 0; k < chain_runs; k++) begin
            // accepting edge, then the seed load edge
            @(posedge clk);
            @(posedge clk);
            if (k < chain_runs - 1) begin
                seed <= chain_seeds[k + 1];
            end
            else begin
                req_val <= 1'b0;
            end
            wait_done(seen);
            if (seen) begin
                check_value("signature", model_signature(chain_seeds[k]), signature);
            end
            if (k < chain_runs - 1) begin
                starts++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (done) begin
                done_pulses++;
                if (done_last) begin
                    errors++;
                    $display("done stayed high for more than one cycle at %0t", $time);
                end
                if (!req_rdy) begin
                    errors++;
                    $display("error at %0t: req_rdy expected 1, got 0", $time);
                end
            end
            done_last = done;
        end
    end

    initial begin
        int gap;
        logic [31:0] draw;
        rng_state = 32'h8c8f13b1;
        errors = 0;
        checks = 0;
        starts = 0;
        done_pulses = 0;
        done_last = 1'b0;
        reset = 1'b1;
        req_val = 1'b0;
        seed = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_value("req_rdy", 32'd1, req_rdy);
        check_value("done", 32'd0, done);
        check_value("signature", 32'd0, signature);

        for (int r = 0; r < random_runs; r++) begin
            run_single(nonzero_seed(), 1);
            draw = lcg();
            gap = int'(draw[31:29]);
            repeat (gap) @(posedge clk);
        end

        // request held high well into the run
        draw = lcg();
        run_single(nonzero_seed(), 20 + int'(draw[31:26]));
        repeat (4) begin
            @(negedge clk);
            check_value("req_rdy", 32'd1, req_rdy);
        end

        run_chain();

        run_single('0, 1);
        check_value("signature", 32'd0, signature);

        // quiet period, a stray run would show up as an extra done
        repeat (200) @(negedge clk);
        checks++;
        if (done_pulses != starts) begin
            errors++;
            $display("%0d done pulses seen for %0d accepted starts", done_pulses, starts);
        end

        $display("checks: %0d, errors: %0d, starts: %0d, done pulses: %0d",
                 checks, errors, starts, done_pulses);
        if (errors == 0) begin
            $display("Verification passed");
        end
        else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
